// File: Bender.yml
package:
  name: mul

sources:
  - design/mul_pkg.sv
  - design/booth_encoder.sv
  - design/wallace_tree.sv
  - design/mul_req_ack.sv
  - design/mul.sv
  - target: test
    files:
      - test/tb_mul.sv

// File: design/booth_encoder.sv
`timescale 1ns/100ps
`default_nettype none

module booth_encoder (
  input  mul_pkg::mul_operands_t op,
  output mul_pkg::pp_array_t     pp
);

  // operands extended to 33 bits
  // top bit is the sign in signed mode, zero otherwise
  logic [mul_pkg::OP_W:0] a_ext;
  logic [mul_pkg::OP_W:0] b_ext;

  // recoding window over a
  // implicit zero below bit 0, extension bit repeated on top
  logic [mul_pkg::OP_W+2:0] a_win;

  // b as a full row and its signed multiples
  mul_pkg::pp_t b_row;
  mul_pkg::pp_t b2_row;
  mul_pkg::pp_t nb_row;
  mul_pkg::pp_t nb2_row;

  assign a_ext = {op.mul_signed & op.a[mul_pkg::OP_W-1], op.a};
  assign b_ext = {op.mul_signed & op.b[mul_pkg::OP_W-1], op.b};

  // group i reads a_win[2i+2:2i], i.e. a[2i+1], a[2i], a[2i-1]
  assign a_win = {a_ext[mul_pkg::OP_W], a_ext, 1'b0};

  // sign-extend b to the row width
  assign b_row = {{(mul_pkg::PP_W - mul_pkg::OP_W - 1){b_ext[mul_pkg::OP_W]}}, b_ext};

  // 2b, wraps at the row width which the tree tolerates
  assign b2_row = b_row << 1;

  // two's complement negatives
  assign nb_row  = ~b_row + 1'b1;
  assign nb2_row = nb_row << 1;

  // radix-4 recoding
  //   000, 111 -> 0
  //   001, 010 -> +b
  //   011      -> +2b
  //   100      -> -2b
  //   101, 110 -> -b
  // each pick lands at weight 4**i
  always_comb begin : pick_rows
    logic [2:0]   grp;
    mul_pkg::pp_t pick;
    for (int i = 0; i < mul_pkg::NUM_PP; i++) begin
      grp = a_win[2*i +: 3];
      case (grp)
        3'b001, 3'b010: begin
          pick = b_row;
        end
        3'b011: begin
          pick = b2_row;
        end
        3'b100: begin
          pick = nb2_row;
        end
        3'b101, 3'b110: begin
          pick = nb_row;
        end
        default: begin
          // runs of equal bits add nothing
          pick = '0;
        end
      endcase
      // upper bits fall off, the sum is only needed mod 2**65
      pp[i] = pick << (2 * i);
    end
  end

  // in unsigned mode group 16 is {0, 0, a[31]}
  // so it adds +b exactly when the top bit of a is set
  // in signed mode it sees {s, s, a[31]}, which is 0 for a matching sign

endmodule

`default_nettype wire

// File: design/mul.sv
`timescale 1ns/100ps
`default_nettype none

module mul (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   req,
  input  mul_pkg::mul_operands_t operands,
  output logic                   ack,
  output mul_pkg::product_t      result
);

  // captured operands into the encoder
  mul_pkg::mul_operands_t op_q;
  // Booth rows into the tree
  mul_pkg::pp_array_t     pp;
  // redundant product back to the controller
  mul_pkg::csa_pair_t     tree_out;
  // loads the mid-tree register
  logic                   stage_en;

  mul_req_ack i_ctrl (
    .clk      (clk),
    .resetn   (resetn),
    .req      (req),
    .operands (operands),
    .op_q     (op_q),
    .stage_en (stage_en),
    .tree_out (tree_out),
    .ack      (ack),
    .result   (result)
  );

  booth_encoder i_booth (
    .op (op_q),
    .pp (pp)
  );

  wallace_tree i_tree (
    .clk      (clk),
    .resetn   (resetn),
    .stage_en (stage_en),
    .pp       (pp),
    .tree_out (tree_out)
  );

endmodule

`default_nettype wire

// File: design/mul_pkg.sv
`default_nettype none

package mul_pkg;

  // operand and full product widths
  localparam int OP_W   = 32;
  localparam int PROD_W = 64;

  // one row of the tree
  // 33 bit extended operand, plus room for the 2b shift and the sign
  localparam int PP_W   = 65;

  // radix-4 groups over the 33 bit extended operand
  // group 16 only sees the extension bit
  localparam int NUM_PP = 17;

  typedef logic [OP_W-1:0]   operand_t;
  typedef logic [PROD_W-1:0] product_t;
  typedef logic [PP_W-1:0]   pp_t;

  // all partial products, row 0 in the low bits
  typedef pp_t [NUM_PP-1:0] pp_array_t;

  // one request as seen at the handshake
  typedef struct packed {
    // 1 for signed, 0 for unsigned
    logic     mul_signed;
    operand_t a;
    operand_t b;
  } mul_operands_t;

  // redundant product that leaves the tree
  // sum + carry, mod 2**PP_W, gives the product
  typedef struct packed {
    pp_t sum;
    pp_t carry;
  } csa_pair_t;

  // controller states, one request in flight
  typedef enum logic [1:0] {
    S_IDLE,
    S_EXEC,
    S_REDUCE,
    S_DONE
  } mul_state_t;

endpackage

`default_nettype wire

// File: design/mul_req_ack.sv
`timescale 1ns/100ps
`default_nettype none

module mul_req_ack (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   req,
  input  mul_pkg::mul_operands_t operands,
  output mul_pkg::mul_operands_t op_q,
  output logic                   stage_en,
  input  mul_pkg::csa_pair_t     tree_out,
  output logic                   ack,
  output mul_pkg::product_t      result
);

  mul_pkg::mul_state_t state;
  mul_pkg::mul_state_t state_nxt;

  // new request taken this cycle
  logic accept;

  // final carry-propagate add, one bit wider than the product
  mul_pkg::pp_t cpa_sum;

  assign accept = (state == mul_pkg::S_IDLE) && req;

  // tree register loads only once per request
  assign stage_en = (state == mul_pkg::S_EXEC);

  // top bit of the row is only extension, dropped on load
  assign cpa_sum = tree_out.sum + tree_out.carry;

  // idle -> exec -> reduce -> done, wait for req low, back to idle
  always_comb begin
    state_nxt = state;
    case (state)
      mul_pkg::S_IDLE: begin
        if (req) begin
          state_nxt = mul_pkg::S_EXEC;
        end
      end
      mul_pkg::S_EXEC: begin
        state_nxt = mul_pkg::S_REDUCE;
      end
      mul_pkg::S_REDUCE: begin
        state_nxt = mul_pkg::S_DONE;
      end
      mul_pkg::S_DONE: begin
        // held req is back-pressure
        if (!req) begin
          state_nxt = mul_pkg::S_IDLE;
        end
      end
      default: begin
        state_nxt = mul_pkg::S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= mul_pkg::S_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // operands sampled once, later changes are ignored
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q <= operands;
    end
  end

  // ack rises with the result, falls when req is seen low
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ack    <= 1'b0;
      result <= '0;
    end else if (state == mul_pkg::S_REDUCE) begin
      ack    <= 1'b1;
      result <= cpa_sum[mul_pkg::PROD_W-1:0];
    end else if (state == mul_pkg::S_DONE && !req) begin
      ack <= 1'b0;
    end
  end

  // requester must still hold req when the product arrives
  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (!resetn)
    $rose(ack) |-> $past(req)
  ) else $error("ack rose without a pending req");

  // no early drop of ack under back-pressure
  a_ack_held: assert property (
    @(posedge clk) disable iff (!resetn)
    ack && req |=> ack
  ) else $error("ack dropped while req still high");

  a_ack_in_done: assert property (
    @(posedge clk) disable iff (!resetn)
    ack |-> state == mul_pkg::S_DONE
  ) else $error("ack high outside the done state");

endmodule

`default_nettype wire

// File: design/wallace_tree.sv
`timescale 1ns/100ps
`default_nettype none

module wallace_tree (
  input  logic               clk,
  input  logic               resetn,
  input  logic               stage_en,
  input  mul_pkg::pp_array_t pp,
  output mul_pkg::csa_pair_t tree_out
);

  // 3:2 compressor over whole rows
  // sum is the xor, carry the majority moved up one bit
  function automatic mul_pkg::csa_pair_t csa3(
    input mul_pkg::pp_t x,
    input mul_pkg::pp_t y,
    input mul_pkg::pp_t z
  );
    mul_pkg::csa_pair_t r;
    r.sum   = x ^ y ^ z;
    // carry out of the top bit is dropped, rows are mod 2**65
    r.carry = ((x & y) | (x & z) | (y & z)) << 1;
    return r;
  endfunction

  // level outputs
  mul_pkg::csa_pair_t l1 [5];
  mul_pkg::csa_pair_t l2 [4];
  mul_pkg::csa_pair_t l3 [2];
  mul_pkg::csa_pair_t l4 [2];
  mul_pkg::csa_pair_t l5;
  mul_pkg::csa_pair_t l6;

  // four rows held between levels four and five
  // [0] l4[0].sum, [1] l4[1].sum, [2] l4[0].carry, [3] l4[1].carry
  mul_pkg::pp_t [3:0] mid_q;

  // level one
  // 17 rows -> 5 pairs, rows 1 and 0 pass through
  assign l1[0] = csa3(pp[16], pp[15], pp[14]);
  assign l1[1] = csa3(pp[13], pp[12], pp[11]);
  assign l1[2] = csa3(pp[10], pp[9],  pp[8]);
  assign l1[3] = csa3(pp[7],  pp[6],  pp[5]);
  assign l1[4] = csa3(pp[4],  pp[3],  pp[2]);

  // level two
  // 12 rows -> 8
  assign l2[0] = csa3(l1[0].sum, l1[1].sum, l1[2].sum);
  assign l2[1] = csa3(l1[3].sum, l1[4].sum, pp[1]);
  assign l2[2] = csa3(pp[0], l1[0].carry, l1[1].carry);
  assign l2[3] = csa3(l1[2].carry, l1[3].carry, l1[4].carry);

  // level three
  // 8 rows -> 6, l2[2].carry and l2[3].carry wait a level
  assign l3[0] = csa3(l2[0].sum, l2[1].sum, l2[2].sum);
  assign l3[1] = csa3(l2[3].sum, l2[0].carry, l2[1].carry);

  // level four
  // 6 rows -> 4
  assign l4[0] = csa3(l3[0].sum, l3[1].sum, l2[2].carry);
  assign l4[1] = csa3(l2[3].carry, l3[0].carry, l3[1].carry);

  // mid-tree register, loaded once per request
  always_ff @(posedge clk) begin
    if (!resetn) begin
      mid_q <= '0;
    end else if (stage_en) begin
      mid_q <= {l4[1].carry, l4[0].carry, l4[1].sum, l4[0].sum};
    end
  end

  // level five
  // 4 rows -> 3
  assign l5 = csa3(mid_q[0], mid_q[1], mid_q[2]);

  // level six
  // 3 rows -> final pair
  assign l6 = csa3(l5.sum, mid_q[3], l5.carry);

  // controller adds these a cycle after stage_en
  assign tree_out = l6;

  // operands are captured a cycle before stage_en
  // so the encoder never feeds unknowns into this register
  a_mid_known: assert property (
    @(posedge clk) disable iff (!resetn)
    !$isunknown(mid_q)
  ) else $error("mid-tree rows unknown after reset");

endmodule

`default_nettype wire

// File: mul.f
design/mul_pkg.sv
design/booth_encoder.sv
design/wallace_tree.sv
design/mul_req_ack.sv
design/mul.sv
test/tb_mul.sv

// File: test/tb_mul.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mul;

  localparam int CLK_PERIOD = 40;
  localparam int N_RAND     = 150;
  localparam int N_HS       = 20;
  // random unsigned, random signed, 5x5 corners in two modes, handshake runs
  localparam int N_TXN      = 2 * N_RAND + 50 + N_HS;
  localparam longint WATCHDOG_NS = (longint'(N_TXN) * 8 + 20) * CLK_PERIOD;

  logic                   clk;
  logic                   resetn;
  logic                   req;
  mul_pkg::mul_operands_t operands;
  logic                   ack;
  mul_pkg::product_t      result;

  integer seed;
  int     n_errors;
  int     n_checks;
  int     test_errors;

  mul i_dut (
    .clk      (clk),
    .resetn   (resetn),
    .req      (req),
    .operands (operands),
    .ack      (ack),
    .result   (result)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // hard stop if ack never comes
  initial begin
    #(WATCHDOG_NS);
    $display("run timed out waiting for ack");
    $display("*** TEST FAILED ***");
    $finish;
  end

  // full-width product of the two extended operands
  function automatic mul_pkg::product_t model_product(input mul_pkg::mul_operands_t op);
    mul_pkg::product_t ea;
    mul_pkg::product_t eb;
    ea = {{32{op.mul_signed & op.a[31]}}, op.a};
    eb = {{32{op.mul_signed & op.b[31]}}, op.b};
    return ea * eb;
  endfunction

  task automatic check_product(input mul_pkg::product_t actual, input mul_pkg::product_t expected,
                               input string what);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("** Error @ %0t: %s product %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_latency(input int cycles, input int expected);
    n_checks++;
    if (cycles != expected) begin
      n_errors++;
      $display("** Error @ %0t: ack after %0d cycles, expected %0d", $time, cycles, expected);
    end
  endtask

  task automatic check_ack(input logic actual, input logic expected, input string what);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("** Error @ %0t: %s ack %b, expected %b", $time, what, actual, expected);
    end
  endtask

  // one edge on, then the drive point
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // fresh random operands on the bus, must never reach the product
  task automatic scramble_operands();
    operands.a          = $random(seed);
    operands.b          = $random(seed);
    operands.mul_signed = $random(seed);
  endtask

  // one full four-phase request
  // optional noisy operands while in flight and during a hold of req
  task automatic run_txn(input mul_pkg::mul_operands_t ops, input int extra, input bit scramble);
    mul_pkg::product_t expected;
    int cycles;
    expected = model_product(ops);
    req      = 1'b1;
    operands = ops;
    cycles   = 0;
    do begin
      next_cycle();
      cycles++;
      // operands taken on the first edge, later bus changes are ignored
      if (scramble) begin
        scramble_operands();
      end
    end while (ack !== 1'b1);
    check_latency(cycles, 3);
    check_product(result, expected, "on ack");
    // back-pressure, nothing may move
    for (int k = 0; k < extra; k++) begin
      if (scramble) begin
        scramble_operands();
      end
      next_cycle();
      check_ack(ack, 1'b1, "held");
      check_product(result, expected, "held");
    end
    req = 1'b0;
    next_cycle();
    check_ack(ack, 1'b0, "after req drop");
    check_product(result, expected, "after ack drop");
  endtask

  task automatic random_txn(input logic mode);
    mul_pkg::mul_operands_t ops;
    ops.mul_signed = mode;
    ops.a = $random(seed);
    ops.b = $random(seed);
    run_txn(ops, 0, 1'b0);
  endtask

  task automatic start_test();
    test_errors = n_errors;
  endtask

  task automatic end_test(input string name);
    $display("test %s: %s", name, (n_errors == test_errors) ? "pass" : "fail");
  endtask

  initial begin
    mul_pkg::operand_t      corners [5];
    mul_pkg::mul_operands_t ops;
    int                     extra;
    clk      = 1'b0;
    resetn   = 1'b0;
    req      = 1'b0;
    operands = '0;
    seed     = 32'heeec;
    n_errors = 0;
    n_checks = 0;
    corners  = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

    start_test();
    // outputs settle on the first reset edge
    for (int i = 0; i < 5; i++) begin
      next_cycle();
      check_ack(ack, 1'b0, "in reset");
      check_product(result, '0, "in reset");
    end
    resetn = 1'b1;
    next_cycle();
    check_ack(ack, 1'b0, "after reset");
    check_product(result, '0, "after reset");
    end_test("reset");

    start_test();
    for (int i = 0; i < N_RAND; i++) begin
      random_txn(1'b0);
    end
    end_test("unsigned_random");

    start_test();
    for (int i = 0; i < N_RAND; i++) begin
      random_txn(1'b1);
    end
    end_test("signed_random");

    // top bit and extension bit of the Booth groups
    start_test();
    for (int m = 0; m < 2; m++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          ops.mul_signed = m[0];
          ops.a = corners[i];
          ops.b = corners[j];
          run_txn(ops, 0, 1'b0);
        end
      end
    end
    end_test("corners");

    // back to back, each request held a random 0 to 5 extra cycles
    start_test();
    for (int i = 0; i < N_HS; i++) begin
      ops.mul_signed = $random(seed);
      ops.a = $random(seed);
      ops.b = $random(seed);
      extra = $unsigned($random(seed)) % 6;
      run_txn(ops, extra, 1'b1);
    end
    end_test("handshake");

    $display("errors %0d, checks %0d", n_errors, n_checks);
    if (n_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
